//--- hw/head_route_stage.sv
`timescale 1ns/1ps

`include "noc_consts.svh"

module head_route_stage (
    input  noc_pkg::coord_t     current_addr,
    input  logic [`NOC_EAW-1:0] in_dest,
    input  noc_pkg::port_t      in_destport,
    input  logic                in_inject,
    output noc_pkg::head_t      head
);

    noc_pkg::coord_t dest;
    noc_pkg::port_t  xy_port;
    logic            bad;

    // endpoint address decode, x in the low bits
    assign dest = noc_pkg::coord_t'(in_dest);

    // range check against the mesh size
    assign bad = int'(dest.x) >= `NOC_NX;

    // port for flits injected here
    xy_port_select u_xy (
        .cur  (current_addr),
        .dest (dest),
        .port (xy_port)
    );

    always_comb begin
        head.dest     = dest;
        head.bad_dest = bad;
        if (bad) begin
            head.port = `NOC_PORT_LOCAL; // sink it here
        end else if (in_inject) begin
            head.port = xy_port;
        end else begin
            // transit flit, port came by look-ahead upstream
            head.port = in_destport;
        end
    end

endmodule

//--- hw/look_ahead_route.sv
`timescale 1ns/1ps

`include "noc_consts.svh"

module look_ahead_route (
    input  noc_pkg::coord_t current_addr,
    route_stage_if.dst      up,
    route_stage_if.src      dn
);

    noc_pkg::head_t  head;
    noc_pkg::coord_t next_addr; // router behind the chosen port
    noc_pkg::port_t  xy_port;
    noc_pkg::route_t route;

    assign head = up.payload;

    // mesh neighbor from the binary port code
    always_comb begin
        next_addr = current_addr;
        case (head.port)
            `NOC_PORT_EAST: begin
                next_addr.x = current_addr.x + 1'b1;
            end
            `NOC_PORT_WEST: begin
                next_addr.x = current_addr.x - 1'b1;
            end
            `NOC_PORT_NORTH: begin
                next_addr.y = current_addr.y - 1'b1;
            end
            `NOC_PORT_SOUTH: begin
                next_addr.y = current_addr.y + 1'b1;
            end
            default: begin
                next_addr = current_addr; // local, flit stays here
            end
        endcase
    end

    // XY decision as the next router will make it
    xy_port_select u_lk_xy (
        .cur  (next_addr),
        .dest (head.dest),
        .port (xy_port)
    );

    always_comb begin
        route.head = head;
        if (head.port == `NOC_PORT_LOCAL) begin
            // no next hop, also covers bad destinations
            route.lkport = `NOC_PORT_LOCAL;
        end else begin
            route.lkport = xy_port;
        end
    end

    // combinational stage, handshake passes straight through
    assign dn.valid   = up.valid;
    assign dn.payload = route;
    assign up.ready   = dn.ready;

endmodule

//--- hw/noc_consts.svh
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// mesh size
`define NOC_NX 5 // columns
`define NOC_NY 4 // rows

// router coordinate widths
`define NOC_RXW 3
`define NOC_RYW 2

// endpoint address, x in the low bits
// one endpoint per router, so it has the router address layout
`define NOC_EAW (`NOC_RXW + `NOC_RYW)

// binary port code
`define NOC_PW 3

`define NOC_PORT_LOCAL 3'd0
`define NOC_PORT_EAST 3'd1 // x + 1
`define NOC_PORT_NORTH 3'd2 // y - 1
`define NOC_PORT_WEST 3'd3 // x - 1
`define NOC_PORT_SOUTH 3'd4 // y + 1

`endif

//--- hw/noc_pkg.sv
package noc_pkg;

`include "noc_consts.svh"

    // binary output port code
    typedef logic [`NOC_PW-1:0] port_t;

    // mesh coordinate, used for router and endpoint addresses alike
    typedef struct packed {
        logic [`NOC_RYW-1:0] y; // upper bits
        logic [`NOC_RXW-1:0] x; // lower bits
    } coord_t;

    // stage 1 payload: decoded head flit with this router's port
    typedef struct packed {
        coord_t dest;       // decoded destination
        port_t  port;       // port taken at this router
        logic   bad_dest;   // destination outside the mesh
    } head_t;

    // stage 2 payload: head plus the look-ahead port
    typedef struct packed {
        head_t head;
        port_t lkport;      // port taken at the next router
    } route_t;

endpackage

//--- hw/route_pipe_reg.sv
`timescale 1ns/1ps

module route_pipe_reg #(
    parameter type payload_t = logic
) (
    input logic        clk,
    input logic        reset,
    route_stage_if.dst up,
    route_stage_if.src dn
);

    payload_t data_q; // held payload
    logic     full_q; // register occupied
    logic     up_fire;
    logic     dn_fire;

    assign up_fire = up.valid & up.ready;
    assign dn_fire = full_q & dn.ready;

    // take a new flit when empty or when the current one leaves this cycle
    assign up.ready = ~full_q | dn.ready;

    assign dn.valid = full_q;
    assign dn.payload = data_q;

    // occupancy flag
    always_ff @(posedge clk) begin
        if (reset) begin
            full_q <= 1'b0;
        end else if (up_fire) begin
            full_q <= 1'b1; // load, also covers pass-through
        end else if (dn_fire) begin
            full_q <= 1'b0; // drained, nothing new
        end
    end

    // payload follows the upstream transfer
    always_ff @(posedge clk) begin
        if (up_fire) begin
            data_q <= up.payload;
        end
    end

endmodule

//--- hw/route_stage_if.sv
`timescale 1ns/1ps

interface route_stage_if #(
    parameter type payload_t = logic
);

    logic     valid;    // payload present
    logic     ready;    // receiver can take it
    payload_t payload;

    // producing side
    modport src (
        output valid,
        output payload,
        input  ready
    );

    // consuming side
    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

//--- hw/route_unit_top.sv
`timescale 1ns/1ps

`include "noc_consts.svh"

module route_unit_top (
    input  logic                clk,
    input  logic                reset,

    // head flit stream in
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`NOC_EAW-1:0] in_dest,
    input  noc_pkg::port_t      in_destport,  // look-ahead port from upstream
    input  logic                in_inject,    // flit from the local NI

    input  noc_pkg::coord_t     current_addr,

    // routed flit stream out
    output logic                out_valid,
    input  logic                out_ready,
    output noc_pkg::port_t      out_destport,
    output noc_pkg::port_t      out_lkdestport,
    output logic [`NOC_EAW-1:0] out_dest,
    output logic                out_bad_dest
);

    noc_pkg::head_t  head_word;
    noc_pkg::route_t out_word;

    // stage links
    route_stage_if #(.payload_t(noc_pkg::head_t))  in_if ();
    route_stage_if #(.payload_t(noc_pkg::head_t))  head_if ();
    route_stage_if #(.payload_t(noc_pkg::route_t)) lk_if ();
    route_stage_if #(.payload_t(noc_pkg::route_t)) out_if ();

    // stage 1: decode and this router's port
    head_route_stage u_head_route (
        .current_addr (current_addr),
        .in_dest      (in_dest),
        .in_destport  (in_destport),
        .in_inject    (in_inject),
        .head         (head_word)
    );

    assign in_if.valid   = in_valid;
    assign in_if.payload = head_word;
    assign in_ready      = in_if.ready;

    route_pipe_reg #(
        .payload_t (noc_pkg::head_t)
    ) u_head_reg (
        .clk   (clk),
        .reset (reset),
        .up    (in_if),
        .dn    (head_if)
    );

    // stage 2: next router and look-ahead port
    look_ahead_route u_look_ahead (
        .current_addr (current_addr),
        .up           (head_if),
        .dn           (lk_if)
    );

    route_pipe_reg #(
        .payload_t (noc_pkg::route_t)
    ) u_out_reg (
        .clk   (clk),
        .reset (reset),
        .up    (lk_if),
        .dn    (out_if)
    );

    // output unpacking
    assign out_if.ready   = out_ready;
    assign out_valid      = out_if.valid;
    assign out_word       = out_if.payload;
    assign out_destport   = out_word.head.port;
    assign out_lkdestport = out_word.lkport;
    assign out_dest       = out_word.head.dest; // back to flat address
    assign out_bad_dest   = out_word.head.bad_dest;

endmodule

//--- hw/xy_port_select.sv
`timescale 1ns/1ps

`include "noc_consts.svh"

module xy_port_select (
    input  noc_pkg::coord_t cur,
    input  noc_pkg::coord_t dest,
    output noc_pkg::port_t  port
);

    logic go_east;
    logic go_west;
    logic go_north;
    logic go_south;

    // x first, y only once x matches
    assign go_east  = dest.x > cur.x;
    assign go_west  = dest.x < cur.x;
    assign go_north = dest.y < cur.y; // row 0 at the top
    assign go_south = dest.y > cur.y;

    always_comb begin
        if (go_east) begin
            port = `NOC_PORT_EAST;
        end else if (go_west) begin
            port = `NOC_PORT_WEST;
        end else if (go_north) begin
            port = `NOC_PORT_NORTH;
        end else if (go_south) begin
            port = `NOC_PORT_SOUTH;
        end else begin
            port = `NOC_PORT_LOCAL; // arrived
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the route unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_route_unit \
        -f tb.f -o sim_route_unit > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_route_unit > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Finished with errors" "$SIM_LOG"; then
    echo "simulation FAILED"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0

//--- tb.f
+incdir+hw
hw/noc_pkg.sv
hw/route_stage_if.sv
hw/route_pipe_reg.sv
hw/xy_port_select.sv
hw/head_route_stage.sv
hw/look_ahead_route.sv
hw/route_unit_top.sv
tb/route_unit_props.sv
tb/tb_route_unit.sv

//--- tb/route_unit_props.sv
`timescale 1ns/1ps

`include "noc_consts.svh"

module route_unit_props (
    input logic                clk,
    input logic                reset,
    input logic                out_valid,
    input logic                out_ready,
    input noc_pkg::port_t      out_destport,
    input noc_pkg::port_t      out_lkdestport,
    input logic [`NOC_EAW-1:0] out_dest,
    input logic                out_bad_dest
);

    property p_idle_after_reset;
        @(posedge clk) reset |=> !out_valid;
    endproperty

    // stalled flit must not change
    property p_hold_on_stall;
        @(posedge clk) disable iff (reset)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_destport) &&
                $stable(out_lkdestport) && $stable(out_dest) && $stable(out_bad_dest));
    endproperty

    property p_local_stays_local;
        @(posedge clk) disable iff (reset)
            (out_valid && out_destport == `NOC_PORT_LOCAL) |-> out_lkdestport == `NOC_PORT_LOCAL;
    endproperty

    a_idle_after_reset: assert property (p_idle_after_reset)
        else $error("out_valid high right after reset");
    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("output flit changed while out_ready was low");
    a_local_stays_local: assert property (p_local_stays_local)
        else $error("local destport with a non-local lkdestport");

endmodule

bind route_unit_top route_unit_props u_props (
    .clk            (clk),
    .reset          (reset),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_destport   (out_destport),
    .out_lkdestport (out_lkdestport),
    .out_dest       (out_dest),
    .out_bad_dest   (out_bad_dest)
);

//--- tb/tb_route_unit.sv
`timescale 1ns/1ps

`include "noc_consts.svh"

module tb_route_unit;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int RXW          = `NOC_RXW;
    localparam int RYW          = `NOC_RYW;
    localparam int NUM_INJECT   = 8;
    localparam int NUM_TRANSIT  = 5;
    localparam int NUM_BAD      = 4;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_LATENCY  = 20;
    localparam int TOTAL_FLITS  = NUM_INJECT + NUM_TRANSIT + NUM_BAD + NUM_RANDOM + NUM_LATENCY;
    localparam int LIMIT_CYCLES = TOTAL_FLITS * 20 + RESET_CYCLES;

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_ready;
    logic [`NOC_EAW-1:0] in_dest;
    noc_pkg::port_t      in_destport;
    logic                in_inject;
    noc_pkg::coord_t     current_addr;
    logic                out_valid;
    logic                out_ready;
    noc_pkg::port_t      out_destport;
    noc_pkg::port_t      out_lkdestport;
    logic [`NOC_EAW-1:0] out_dest;
    logic                out_bad_dest;

    logic [11:0] exp_q[$];    // {dest, port, bad, lkport}
    int          accept_q[$]; // edge each flit went in
    int          cyc;
    int          errors;
    bit          toggle_ready;
    bit          check_latency;

    route_unit_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_dest        (in_dest),
        .in_destport    (in_destport),
        .in_inject      (in_inject),
        .current_addr   (current_addr),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_destport   (out_destport),
        .out_lkdestport (out_lkdestport),
        .out_dest       (out_dest),
        .out_bad_dest   (out_bad_dest)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc = cyc + 1; // edge counter
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, actual,
                     expected);
            $display("Finished with errors");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [`NOC_EAW-1:0] addr_of(input int x, input int y);
        return {RYW'(y), RXW'(x)}; // x in the low bits
    endfunction

    // dimension order, x before y, row 0 at the top
    function automatic noc_pkg::port_t xy_ref(input int cx, input int cy, input int dx,
                                              input int dy);
        if (dx > cx)
            return `NOC_PORT_EAST;
        if (dx < cx)
            return `NOC_PORT_WEST;
        if (dy < cy)
            return `NOC_PORT_NORTH;
        if (dy > cy)
            return `NOC_PORT_SOUTH;
        return `NOC_PORT_LOCAL;
    endfunction

    function automatic logic [11:0] expect_route(input noc_pkg::coord_t cur,
                                                 input logic [`NOC_EAW-1:0] dest,
                                                 input noc_pkg::port_t destport,
                                                 input logic inject);
        int             dx;
        int             dy;
        int             nx;
        int             ny;
        logic           bad;
        noc_pkg::port_t port;
        noc_pkg::port_t lk;
        dx = int'(dest[RXW-1:0]);
        dy = int'(dest[RXW+RYW-1:RXW]);
        nx = int'(cur.x);
        ny = int'(cur.y);
        bad = dx >= `NOC_NX;
        if (bad)
            port = `NOC_PORT_LOCAL;
        else if (inject)
            port = xy_ref(nx, ny, dx, dy);
        else
            port = destport; // transit keeps its port
        case (port)
            `NOC_PORT_EAST:  nx = nx + 1;
            `NOC_PORT_WEST:  nx = nx - 1;
            `NOC_PORT_NORTH: ny = ny - 1;
            `NOC_PORT_SOUTH: ny = ny + 1;
            default:         nx = nx;
        endcase
        if (port == `NOC_PORT_LOCAL)
            lk = `NOC_PORT_LOCAL;
        else
            lk = xy_ref(nx, ny, dx, dy); // decision at the neighbor
        return {dest, port, bad, lk};
    endfunction

    // holds the flit until the edge that takes it
    task automatic send_flit(input logic [`NOC_EAW-1:0] dest, input noc_pkg::port_t destport,
                             input logic inject);
        bit accepted;
        in_valid    = 1'b1;
        in_dest     = dest;
        in_destport = destport;
        in_inject   = inject;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            if (accepted) begin
                exp_q.push_back(expect_route(current_addr, dest, destport, inject));
                accept_q.push_back(cyc + 1);
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    // output monitor, sampled mid cycle where everything is settled
    initial begin
        logic [11:0] exp_word;
        int          start;
        forever begin
            @(negedge clk);
            if (!reset && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("an output flit appeared with no flit pending, dest %0d",
                             out_dest);
                    $display("Finished with errors");
                    $fatal(1, "unexpected output flit");
                end else begin
                    exp_word = exp_q.pop_front();
                    start = accept_q.pop_front();
                    check_value("out_dest", 32'(out_dest), 32'(exp_word[11:7]));
                    check_value("out_destport", 32'(out_destport), 32'(exp_word[6:4]));
                    check_value("out_bad_dest", 32'(out_bad_dest), 32'(exp_word[3]));
                    check_value("out_lkdestport", 32'(out_lkdestport), 32'(exp_word[2:0]));
                    if (check_latency)
                        check_value("latency", 32'(cyc + 1 - start), 32'd2);
                end
            end
        end
    end

    // random back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (toggle_ready)
                out_ready = 1'($urandom_range(0, 1));
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    task automatic test_reset_idle();
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'd1);
        @(posedge clk);
        #1;
    endtask

    task automatic test_injected();
        int xs[NUM_INJECT];
        int ys[NUM_INJECT];
        xs = '{4, 0, 2, 2, 2, 3, 1, 4};
        ys = '{1, 1, 0, 3, 1, 0, 3, 3};
        current_addr.x = 3'd2;
        current_addr.y = 2'd1;
        for (int i = 0; i < NUM_INJECT; i++) begin
            send_flit(addr_of(xs[i], ys[i]), 3'($urandom_range(0, 4)), 1'b1); // port ignored
        end
        wait_drain();
    endtask

    task automatic test_transit();
        int             xs[NUM_TRANSIT];
        int             ys[NUM_TRANSIT];
        noc_pkg::port_t ports[NUM_TRANSIT];
        xs = '{4, 0, 2, 1, 2};
        ys = '{3, 0, 0, 3, 1};
        ports = '{`NOC_PORT_EAST, `NOC_PORT_WEST, `NOC_PORT_NORTH, `NOC_PORT_SOUTH,
                  `NOC_PORT_LOCAL};
        for (int i = 0; i < NUM_TRANSIT; i++) begin
            send_flit(addr_of(xs[i], ys[i]), ports[i], 1'b0);
        end
        wait_drain();
    endtask

    task automatic test_bad_dest();
        int xs[NUM_BAD];
        int ys[NUM_BAD];
        xs = '{5, 6, 7, 5};
        ys = '{0, 2, 3, 1};
        for (int i = 0; i < NUM_BAD; i++) begin
            send_flit(addr_of(xs[i], ys[i]), `NOC_PORT_SOUTH, 1'(i % 2));
        end
        wait_drain();
    endtask

    task automatic test_random_stream();
        current_addr.x = 3'(1 + $urandom_range(0, 2)); // interior router
        current_addr.y = 2'(1 + $urandom_range(0, 1));
        toggle_ready = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_flit(5'($urandom), 3'($urandom_range(0, 4)), 1'($urandom_range(0, 1)));
        end
        toggle_ready = 1'b0;
        out_ready = 1'b1;
        wait_drain();
    endtask

    task automatic test_latency();
        out_ready = 1'b1;
        check_latency = 1'b1;
        for (int i = 0; i < NUM_LATENCY; i++) begin
            send_flit(5'($urandom), 3'($urandom_range(0, 4)), 1'($urandom_range(0, 1)));
        end
        wait_drain();
        check_latency = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hea45));
        errors = 0;
        toggle_ready = 1'b0;
        check_latency = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_dest = '0;
        in_destport = `NOC_PORT_LOCAL;
        in_inject = 1'b0;
        current_addr = '0;
        out_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_idle();
        test_injected();
        test_transit();
        test_bad_dest();
        test_random_stream();
        test_latency();
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
